//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_branch_predictor
FILELIST  = branch_predictor.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- branch_predictor.f
src/bp_pkg.sv
src/pht_port_if.sv
src/pht_ram.sv
src/bp_index_hash.sv
src/bp_sweep_counter.sv
src/bp_control_fsm.sv
src/bp_counter_update.sv
src/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- src/bp_control_fsm.sv
`timescale 1ns/1ps

// Clear/run sequencing of the predictor
module bp_control_fsm
    import bp_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sweep_last,
    output logic sweep_en,
    output logic clear_mode,
    output logic ready
);

    bp_state_t state;
    bp_state_t state_next;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_CLEAR: begin
                // Last entry gets written on this edge
                if (sweep_last) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                state_next = ST_RUN;
            end
            default: begin
                state_next = ST_CLEAR;
            end
        endcase
    end

    ////////////////////
    // State and ready
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_CLEAR;
            ready <= 1'b0;
        end else begin
            state <= state_next;
            ready <= (state_next == ST_RUN);
        end
    end

    assign sweep_en   = (state == ST_CLEAR);
    assign clear_mode = (state == ST_CLEAR);

endmodule

//--- src/bp_counter_update.sv
`timescale 1ns/1ps

// Counter read-modify-write on PHT port 1, plus the clear writes
module bp_counter_update
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear_mode,
    input  pht_index_t sweep_addr,
    input  logic       upd_valid,
    input  logic       upd_taken,
    input  pht_index_t upd_index,
    pht_port_if.user   upd_port
);

    // Stage 1 registers, read in flight
    logic       s1_valid;
    pht_index_t s1_index;
    logic       s1_taken;

    // Last written entry, kept for one cycle
    logic       fwd_valid;
    pht_index_t fwd_index;
    ctr_t       fwd_ctr;

    ctr_t       ctr_old;
    ctr_t       ctr_new;

    function automatic ctr_t ctr_saturate(input ctr_t ctr, input logic taken);
        ctr_t result;
        result = ctr;
        if (taken && (ctr != CTR_STRONG_T)) begin
            result = ctr + 2'd1;
        end else if (!taken && (ctr != CTR_STRONG_NT)) begin
            result = ctr - 2'd1;
        end
        return result;
    endfunction

    ////////////////////
    // Stage 1
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= upd_valid && !clear_mode;
        end
    end

    always_ff @(posedge clk) begin
        s1_index <= upd_index;
        s1_taken <= upd_taken;
    end

    ////////////////////
    // Stage 2
    ////////////////////

    // RAM still holds the old value if the same entry was written last cycle
    assign ctr_old = (fwd_valid && (fwd_index == s1_index)) ? fwd_ctr : upd_port.rdata;
    assign ctr_new = ctr_saturate(ctr_old, s1_taken);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= s1_valid && !clear_mode;
        end
    end

    always_ff @(posedge clk) begin
        fwd_index <= s1_index;
        fwd_ctr   <= ctr_new;
    end

    // Port 1 mux, clear first, then the stage 2 write, then a new read
    always_comb begin
        if (clear_mode) begin
            upd_port.en    = 1'b1;
            upd_port.we    = 1'b1;
            upd_port.addr  = sweep_addr;
            upd_port.wdata = CTR_WEAK_NT;
        end else if (s1_valid) begin
            upd_port.en    = 1'b1;
            upd_port.we    = 1'b1;
            upd_port.addr  = s1_index;
            upd_port.wdata = ctr_new;
        end else begin
            upd_port.en    = upd_valid;
            upd_port.we    = 1'b0;
            upd_port.addr  = upd_index;
            upd_port.wdata = ctr_new;
        end
    end

endmodule

//--- src/bp_index_hash.sv
`timescale 1ns/1ps

// Global history and gshare index generation
module bp_index_hash
    import bp_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready,
    input  logic                pred_req,
    input  logic [PC_WIDTH-1:0] pred_pc,
    input  logic                upd_valid,
    input  logic [PC_WIDTH-1:0] upd_pc,
    input  logic                upd_taken,
    output pht_index_t          upd_index,
    output logic                pred_valid,
    pht_port_if.user            pred_port
);

    pht_index_t ghr;

    // Word address bits folded with the history
    function automatic pht_index_t gshare_index(
        input logic [PC_WIDTH-1:0] pc,
        input pht_index_t          hist
    );
        return pc[PC_INDEX_LSB +: PHT_INDEX_BITS] ^ hist;
    endfunction

    ////////////////////
    // History register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (upd_valid && ready) begin
            ghr <= {ghr[PHT_INDEX_BITS-2:0], upd_taken};
        end
    end

    // Result comes back from the RAM one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= pred_req && ready;
        end
    end

    assign upd_index = gshare_index(upd_pc, ghr);

    // Predict port only reads
    assign pred_port.addr  = gshare_index(pred_pc, ghr);
    assign pred_port.en    = pred_req && ready;
    assign pred_port.we    = 1'b0;
    assign pred_port.wdata = CTR_WEAK_NT;

endmodule

//--- src/bp_pkg.sv
package bp_pkg;

    ////////////////////
    // Widths and sizes
    ////////////////////

    localparam int PC_WIDTH = 32;

    // Index width also sets the GHR length
    localparam int PHT_INDEX_BITS = 8;
    localparam int PHT_ENTRIES = 1 << PHT_INDEX_BITS;

    // Lowest PC bit that enters the hash
    localparam int PC_INDEX_LSB = 2;

    typedef logic [PHT_INDEX_BITS-1:0] pht_index_t;
    typedef logic [1:0] ctr_t;

    ////////////////////
    // Counter encodings
    ////////////////////

    // Upper counter bit is the predicted direction
    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_NT = 2'd1;
    localparam ctr_t CTR_WEAK_T = 2'd2;
    localparam ctr_t CTR_STRONG_T = 2'd3;

    ////////////////////
    // Controller states
    ////////////////////

    typedef enum logic {
        ST_CLEAR,
        ST_RUN
    } bp_state_t;

endpackage

//--- src/bp_sweep_counter.sv
`timescale 1ns/1ps

// Walks every PHT entry once during clearing
module bp_sweep_counter
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sweep_en,
    output pht_index_t sweep_addr,
    output logic       sweep_last
);

    localparam pht_index_t LAST_ADDR = pht_index_t'(PHT_ENTRIES - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_addr <= '0;
        end else if (sweep_en) begin
            // Wraps to zero after the final entry
            sweep_addr <= sweep_addr + pht_index_t'(1);
        end
    end

    assign sweep_last = (sweep_addr == LAST_ADDR);

endmodule

//--- src/branch_predictor.sv
`timescale 1ns/1ps

// Gshare branch direction predictor
module branch_predictor
    import bp_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // Fetch side
    input  logic                pred_req,
    input  logic [PC_WIDTH-1:0] pred_pc,
    // Retire side
    input  logic                upd_valid,
    input  logic [PC_WIDTH-1:0] upd_pc,
    input  logic                upd_taken,
    // Status and prediction
    output logic                ready,
    output logic                pred_valid,
    output logic                pred_taken
);

    logic       sweep_en;
    logic       sweep_last;
    logic       clear_mode;
    pht_index_t sweep_addr;
    pht_index_t upd_index;

    ////////////////////
    // PHT and its ports
    ////////////////////

    // Port 0 predicts, port 1 updates and clears
    pht_port_if pred_port ();
    pht_port_if upd_port ();

    pht_ram pht_ram_inst (
        .clk (clk),
        .p0  (pred_port),
        .p1  (upd_port)
    );

    ////////////////////
    // Index and history
    ////////////////////

    bp_index_hash bp_index_hash_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .pred_req   (pred_req),
        .pred_pc    (pred_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_index  (upd_index),
        .pred_valid (pred_valid),
        .pred_port  (pred_port)
    );

    ////////////////////
    // Clearing control
    ////////////////////

    bp_sweep_counter bp_sweep_counter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_en   (sweep_en),
        .sweep_addr (sweep_addr),
        .sweep_last (sweep_last)
    );

    bp_control_fsm bp_control_fsm_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sweep_last (sweep_last),
        .sweep_en   (sweep_en),
        .clear_mode (clear_mode),
        .ready      (ready)
    );

    bp_counter_update bp_counter_update_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_mode (clear_mode),
        .sweep_addr (sweep_addr),
        .upd_valid  (upd_valid),
        .upd_taken  (upd_taken),
        .upd_index  (upd_index),
        .upd_port   (upd_port)
    );

    // Direction is the counter's upper bit
    assign pred_taken = pred_port.rdata[1];

endmodule

//--- src/pht_port_if.sv
`timescale 1ns/1ps

// One port of the pattern history table RAM
interface pht_port_if
    import bp_pkg::*;
();

    pht_index_t addr;
    logic en;
    logic we;
    ctr_t wdata;
    // Old entry at addr, one clock after en
    ctr_t rdata;

    modport ram (
        input  addr,
        input  en,
        input  we,
        input  wdata,
        output rdata
    );

    modport user (
        output addr,
        output en,
        output we,
        output wdata,
        input  rdata
    );

endinterface

//--- src/pht_ram.sv
`timescale 1ns/1ps

// True dual-port PHT of 2-bit counters, read-first on both ports
module pht_ram
    import bp_pkg::*;
(
    input logic clk,
    pht_port_if.ram p0,
    pht_port_if.ram p1
);

    (* ram_style = "block" *) ctr_t mem [PHT_ENTRIES];

    ////////////////////
    // Port 0
    ////////////////////

    always_ff @(posedge clk) begin
        if (p0.en) begin
            p0.rdata <= mem[p0.addr];
            if (p0.we) begin
                mem[p0.addr] <= p0.wdata;
            end
        end
    end

    ////////////////////
    // Port 1
    ////////////////////

    // Same-address access from both ports returns the old entry
    always_ff @(posedge clk) begin
        if (p1.en) begin
            p1.rdata <= mem[p1.addr];
            if (p1.we) begin
                mem[p1.addr] <= p1.wdata;
            end
        end
    end

endmodule

//--- testbench/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT = PHT_ENTRIES + 20;
    localparam int NUM_RANDOM = 40;

    typedef enum logic [1:0] {
        OP_RESET,
        OP_WAIT,
        OP_PRED,
        OP_UPD
    } op_t;

    // pin XORs the model GHR into pc so the index stays at pc's zero-history entry
    typedef struct packed {
        int                  test;
        op_t                 op;
        logic [PC_WIDTH-1:0] pc;
        logic                taken;
        logic                pin;
        logic                chk;
        pht_index_t          idx;
        int                  gap;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                pred_req;
    logic [PC_WIDTH-1:0] pred_pc;
    logic                upd_valid;
    logic [PC_WIDTH-1:0] upd_pc;
    logic                upd_taken;
    logic                ready;
    logic                pred_valid;
    logic                pred_taken;

    // Reference model
    ctr_t       model_pht [PHT_ENTRIES];
    pht_index_t model_ghr;
    logic       model_ready;

    row_t        rows [$];
    logic [31:0] lfsr;
    int          total_checks;
    int          total_errors;
    int          test_checks;
    int          test_errors;

    always #4 clk = ~clk;

    branch_predictor branch_predictor_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_req   (pred_req),
        .pred_pc    (pred_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .ready      (ready),
        .pred_valid (pred_valid),
        .pred_taken (pred_taken)
    );

    ////////////////////
    // Model and random
    ////////////////////

    function automatic pht_index_t model_index(input logic [PC_WIDTH-1:0] pc,
                                               input pht_index_t hist);
        pht_index_t word;
        word = pc[PC_INDEX_LSB +: PHT_INDEX_BITS];
        return word ^ hist;
    endfunction

    function automatic ctr_t next_ctr(input ctr_t c, input logic taken);
        case (c)
            CTR_STRONG_NT: return taken ? CTR_WEAK_NT : CTR_STRONG_NT;
            CTR_WEAK_NT:   return taken ? CTR_WEAK_T : CTR_STRONG_NT;
            CTR_WEAK_T:    return taken ? CTR_STRONG_T : CTR_WEAK_NT;
            default:       return taken ? CTR_STRONG_T : CTR_WEAK_T;
        endcase
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_taken(input logic got, input logic exp, input string name);
        total_checks++;
        test_checks++;
        if (got !== exp) begin
            total_errors++;
            test_errors++;
            $display("FAILED t=%0t %s: got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_ctr_idx(input pht_index_t got, input pht_index_t exp,
                                 input string name);
        total_checks++;
        test_checks++;
        if (got !== exp) begin
            total_errors++;
            test_errors++;
            $display("FAILED t=%0t %s: got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        total_checks++;
        test_checks++;
        if (got !== exp) begin
            total_errors++;
            test_errors++;
            $display("FAILED t=%0t ready: got %0b expected %0b", $time, got, exp);
        end
    endtask

    ////////////////////
    // Bus operations
    ////////////////////

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        pred_req  <= 1'b0;
        upd_valid <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_ready(ready, 1'b0);
        check_taken(pred_valid, 1'b0, "pred_valid");
        @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            model_pht[i] = CTR_WEAK_NT;
        end
        model_ghr = '0;
        model_ready = 1'b0;
    endtask

    task automatic wait_ready(output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            if (ready) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (ok) begin
            model_ready = 1'b1;
        end else begin
            $display("Timeout: ready stayed low for %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic predict_and_check(input logic [PC_WIDTH-1:0] pc, input logic chk,
                                     input pht_index_t exp_idx, output logic ok);
        pht_index_t idx;
        int         cycles;
        logic       seen;
        idx = model_index(pc, model_ghr);
        ok = 1'b1;
        if (chk) begin
            check_ctr_idx(idx, exp_idx, "model index");
        end
        @(posedge clk);
        pred_req <= 1'b1;
        pred_pc  <= pc;
        @(posedge clk);
        pred_req <= 1'b0;
        if (model_ready) begin
            seen = 1'b0;
            cycles = 0;
            while (!seen && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                if (pred_valid) begin
                    seen = 1'b1;
                end else begin
                    cycles++;
                end
            end
            if (seen) begin
                check_ready(ready, 1'b1);
                check_taken(pred_taken, model_pht[idx][1], "pred_taken");
            end else begin
                $display("Timeout: no pred_valid for PC %08h", pc);
                ok = 1'b0;
            end
        end else begin
            // Request must be dropped while clearing
            for (int i = 0; i < 3; i++) begin
                @(negedge clk);
                check_ready(ready, 1'b0);
                check_taken(pred_valid, 1'b0, "pred_valid");
            end
        end
    endtask

    task automatic send_update(input logic [PC_WIDTH-1:0] pc, input logic taken);
        pht_index_t idx;
        @(posedge clk);
        upd_valid <= 1'b1;
        upd_pc    <= pc;
        upd_taken <= taken;
        @(posedge clk);
        upd_valid <= 1'b0;
        if (model_ready) begin
            idx = model_index(pc, model_ghr);
            model_pht[idx] = next_ctr(model_pht[idx], taken);
            model_ghr = {model_ghr[PHT_INDEX_BITS-2:0], taken};
        end
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic add_row(input int test, input op_t op, input logic [PC_WIDTH-1:0] pc,
                           input logic taken, input logic pin, input logic chk,
                           input pht_index_t idx, input int gap);
        row_t r;
        r.test = test;
        r.op = op;
        r.pc = pc;
        r.taken = taken;
        r.pin = pin;
        r.chk = chk;
        r.idx = idx;
        r.gap = gap;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] op_bit;
        logic [31:0] pc_bits;
        logic [31:0] tk_bit;
        logic [31:0] gap_bits;
        // Fresh table, all entries weakly not taken
        add_row(1, OP_RESET, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(1, OP_WAIT, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(1, OP_PRED, 32'h0000_0000, 1'b0, 1'b0, 1'b1, 8'h00, 0);
        add_row(1, OP_PRED, 32'h0000_0040, 1'b0, 1'b0, 1'b1, 8'h10, 0);
        add_row(1, OP_PRED, 32'h0000_0ffc, 1'b0, 1'b0, 1'b1, 8'hff, 0);
        add_row(1, OP_PRED, 32'h1234_5678, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        // Traffic during the clear sweep
        add_row(2, OP_RESET, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(2, OP_PRED, 32'h0000_0040, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(2, OP_UPD, 32'h0000_0040, 1'b1, 1'b0, 1'b0, 8'h00, 1);
        add_row(2, OP_UPD, 32'h0000_0040, 1'b1, 1'b0, 1'b0, 8'h00, 1);
        add_row(2, OP_WAIT, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(2, OP_PRED, 32'h0000_0040, 1'b0, 1'b0, 1'b1, 8'h10, 0);
        add_row(2, OP_PRED, 32'h0000_0044, 1'b0, 1'b0, 1'b1, 8'h11, 0);
        // Stray history bits from the dropped updates would move this entry
        add_row(2, OP_UPD, 32'h0000_0040, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(2, OP_PRED, 32'h0000_0040, 1'b0, 1'b1, 1'b1, 8'h10, 0);
        // One pinned entry up to strong taken and back one step
        add_row(3, OP_UPD, 32'h0000_0100, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(3, OP_UPD, 32'h0000_0100, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(3, OP_PRED, 32'h0000_0100, 1'b0, 1'b1, 1'b1, 8'h40, 0);
        add_row(3, OP_UPD, 32'h0000_0100, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(3, OP_UPD, 32'h0000_0100, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(3, OP_UPD, 32'h0000_0100, 1'b0, 1'b1, 1'b0, 8'h00, 1);
        add_row(3, OP_PRED, 32'h0000_0100, 1'b0, 1'b1, 1'b1, 8'h40, 0);
        // Same PC, GHR 1 then GHR 3
        add_row(4, OP_RESET, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(4, OP_WAIT, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(4, OP_UPD, 32'h0000_0044, 1'b1, 1'b0, 1'b0, 8'h00, 1);
        add_row(4, OP_PRED, 32'h0000_0040, 1'b0, 1'b0, 1'b1, 8'h11, 0);
        add_row(4, OP_UPD, 32'h0000_0080, 1'b1, 1'b0, 1'b0, 8'h00, 1);
        add_row(4, OP_PRED, 32'h0000_0040, 1'b0, 1'b0, 1'b1, 8'h13, 0);
        add_row(4, OP_PRED, 32'h0000_0044, 1'b0, 1'b0, 1'b1, 8'h12, 0);
        // Small PC set so entries get hit more than once
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(1, op_bit);
            take_bits(4, pc_bits);
            take_bits(1, tk_bit);
            take_bits(2, gap_bits);
            add_row(5, op_bit[0] ? OP_UPD : OP_PRED,
                    32'h0000_1000 | {26'd0, pc_bits[3:0], 2'b00},
                    tk_bit[0], 1'b0, 1'b0, 8'h00, 1 + int'(gap_bits[1:0]));
        end
        // Train an entry, then reset in the middle of the run
        add_row(6, OP_UPD, 32'h0000_0200, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(6, OP_UPD, 32'h0000_0200, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(6, OP_PRED, 32'h0000_0200, 1'b0, 1'b1, 1'b1, 8'h80, 0);
        add_row(6, OP_RESET, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(6, OP_WAIT, 32'h0, 1'b0, 1'b0, 1'b0, 8'h00, 0);
        add_row(6, OP_PRED, 32'h0000_0200, 1'b0, 1'b1, 1'b1, 8'h80, 0);
        add_row(6, OP_PRED, 32'h0000_1004, 1'b0, 1'b0, 1'b1, 8'h01, 0);
        // Old history left in the GHR would train and read other entries
        add_row(6, OP_UPD, 32'h0000_0200, 1'b1, 1'b1, 1'b0, 8'h00, 1);
        add_row(6, OP_PRED, 32'h0000_0200, 1'b0, 1'b1, 1'b1, 8'h80, 0);
    endtask

    task automatic report_test(input int test);
        $display("test %0d: %0d checks, %0d errors", test, test_checks, test_errors);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        row_t                r;
        logic [PC_WIDTH-1:0] pc_eff;
        logic                ok;
        logic                aborted;
        int                  row_i;
        int                  cur_test;
        rst_n = 1'b0;
        pred_req = 1'b0;
        pred_pc = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_taken = 1'b0;
        model_ghr = '0;
        model_ready = 1'b0;
        lfsr = 32'd77835;
        total_checks = 0;
        total_errors = 0;
        test_checks = 0;
        test_errors = 0;
        aborted = 1'b0;
        row_i = 0;
        cur_test = 0;
        build_table();
        while (row_i < rows.size() && !aborted) begin
            r = rows[row_i];
            if (r.test != cur_test) begin
                if (cur_test != 0) begin
                    report_test(cur_test);
                end
                cur_test = r.test;
                test_checks = 0;
                test_errors = 0;
            end
            pc_eff = r.pin ? (r.pc ^ (PC_WIDTH'(model_ghr) << PC_INDEX_LSB)) : r.pc;
            case (r.op)
                OP_RESET: apply_reset();
                OP_WAIT: begin
                    wait_ready(ok);
                    aborted = !ok;
                end
                OP_PRED: begin
                    predict_and_check(pc_eff, r.chk, r.idx, ok);
                    aborted = !ok;
                end
                default: send_update(pc_eff, r.taken);
            endcase
            repeat (r.gap) @(posedge clk);
            row_i++;
        end
        report_test(cur_test);
        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (aborted || total_errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule
